// File: common/fetch_pkg.sv
// Shared definitions for the instruction-fetch subsystem.
// Widths, address-field helpers and the cache controller states.
// Every RTL block takes this package by a wildcard import.

package fetch_pkg;

    // ------------------------------------------------------------------
    // Widths and types
    // ------------------------------------------------------------------
    typedef logic [39:0]  addr_t;
    typedef logic [31:0]  paddr_t;
    typedef logic [25:0]  block_addr_t;
    typedef logic [127:0] beat_t;
    typedef logic [1:0]   beat_idx_t;
    typedef logic [511:0] line_t;
    typedef logic [31:0]  insn_t;
    typedef logic [23:0]  brom_addr_t;

    localparam int        BEATS_PER_LINE = 4;
    // Grant beat that carries the acknowledge
    localparam beat_idx_t LAST_BEAT      = 2'd3;

    // Cache controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        FILL,
        FLUSH
    } icache_state_e;

    // ------------------------------------------------------------------
    // Address field helpers
    // ------------------------------------------------------------------
    // Physical address is the low part with translation off
    function automatic paddr_t paddr_of(addr_t addr);
        return addr[31:0];
    endfunction

    function automatic block_addr_t block_of(paddr_t paddr);
        return paddr[31:6];
    endfunction

    // Which 128-bit quarter of the line holds the word
    function automatic beat_idx_t quarter_of(paddr_t paddr);
        return paddr[5:4];
    endfunction

    function automatic brom_addr_t brom_addr_of(addr_t addr);
        return addr[25:2];
    endfunction

    function automatic beat_t line_quarter(line_t line, beat_idx_t q);
        return line[q * $bits(beat_t) +: $bits(beat_t)];
    endfunction

    function automatic insn_t block_word(beat_t blk, logic [1:0] w);
        return blk[w * $bits(insn_t) +: $bits(insn_t)];
    endfunction

endpackage

// File: common/icache_if.sv
// Request and response signals between the fetch port and the cache
// controller. One request in flight, response is a single-cycle pulse
// carrying the quarter line that holds the requested word.

interface icache_if import fetch_pkg::*; ();

    // Request, fetch port to cache
    logic   req_valid;
    paddr_t req_paddr;
    logic   req_ready;

    // Response, cache to fetch port
    logic   resp_valid;
    beat_t  resp_block;

    modport port (
        output req_valid,
        output req_paddr,
        input  req_ready,
        input  resp_valid,
        input  resp_block
    );

    modport cache (
        input  req_valid,
        input  req_paddr,
        output req_ready,
        output resp_valid,
        output resp_block
    );

endinterface

// File: common/ifill_if.sv
// Line refill handshake between the cache controller and the refill
// engine. fill_req and fill_done are single-cycle pulses, fill_line is
// only meaningful while fill_done is high.

interface ifill_if import fetch_pkg::*; ();

    // Controller side
    logic        fill_req;
    block_addr_t fill_block;

    // Refill engine side
    logic        fill_done;
    line_t       fill_line;
    logic        fill_busy;

    modport ctrl (
        output fill_req,
        output fill_block,
        input  fill_done,
        input  fill_line,
        input  fill_busy
    );

    modport refill (
        input  fill_req,
        input  fill_block,
        output fill_done,
        output fill_line,
        output fill_busy
    );

endinterface

// File: verilog/fetch_port.sv
// Fetch-stage side of the subsystem. Accepts one request at a time,
// routes it to the boot ROM or the instruction cache, picks the word
// out of the returned quarter line and holds it until the fetch stage
// takes it.

module fetch_port import fetch_pkg::*; (
    input  logic       CLK,
    input  logic       RST,

    input  logic       fetch_req_valid_i,
    input  addr_t      fetch_req_addr_i,
    output logic       fetch_req_ready_o,
    output logic       fetch_resp_valid_o,
    output insn_t      fetch_resp_insn_o,
    input  logic       fetch_resp_ready_i,

    input  logic       boot_mode_i,
    input  logic       brom_ready_i,
    input  logic       brom_resp_valid_i,
    input  insn_t      brom_resp_data_i,
    output logic       brom_req_valid_o,
    output brom_addr_t brom_req_addr_o,

    icache_if.port     ic
);

    logic       pend_q;
    logic       route_boot_q;
    logic [1:0] word_sel_q;
    logic       resp_valid_q;
    insn_t      resp_insn_q;
    logic       brom_valid_q;
    brom_addr_t brom_addr_q;
    logic       port_free;
    logic       accept;
    logic       boot_resp;
    logic       cache_resp;

    // Free only with nothing outstanding and nothing held
    assign port_free         = !pend_q && !resp_valid_q;
    assign fetch_req_ready_o = port_free && (boot_mode_i || ic.req_ready);
    assign accept            = fetch_req_valid_i && fetch_req_ready_o;

    // Cache request goes out in the same cycle as the fetch request
    assign ic.req_valid = fetch_req_valid_i && port_free && !boot_mode_i;
    assign ic.req_paddr = paddr_of(fetch_req_addr_i);

    assign boot_resp  = pend_q && route_boot_q && brom_resp_valid_i;
    assign cache_resp = pend_q && !route_boot_q && ic.resp_valid;

    // ------------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            pend_q       <= 1'b0;
            resp_valid_q <= 1'b0;
            brom_valid_q <= 1'b0;
        end else begin
            if (accept) begin
                pend_q <= 1'b1;
            end else if (boot_resp || cache_resp) begin
                pend_q <= 1'b0;
            end

            if (boot_resp || cache_resp) begin
                resp_valid_q <= 1'b1;
            end else if (fetch_resp_ready_i) begin
                resp_valid_q <= 1'b0;
            end

            // Boot ROM request held until the ROM is ready
            if (accept && boot_mode_i) begin
                brom_valid_q <= 1'b1;
            end else if (brom_ready_i) begin
                brom_valid_q <= 1'b0;
            end
        end
    end

    // Request fields and response payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            route_boot_q <= boot_mode_i;
            word_sel_q   <= fetch_req_addr_i[3:2];
            brom_addr_q  <= brom_addr_of(fetch_req_addr_i);
        end
        if (boot_resp) begin
            resp_insn_q <= brom_resp_data_i;
        end else if (cache_resp) begin
            resp_insn_q <= block_word(ic.resp_block, word_sel_q);
        end
    end

    assign fetch_resp_valid_o = resp_valid_q;
    assign fetch_resp_insn_o  = resp_insn_q;
    assign brom_req_valid_o   = brom_valid_q;
    assign brom_req_addr_o    = brom_addr_q;

    // Held response does not change until taken
    a_resp_hold: assert property (@(posedge CLK) disable iff (!RST)
        resp_valid_q && !fetch_resp_ready_i |=> resp_valid_q && $stable(resp_insn_q));

endmodule

// File: icache/icache_ctrl.sv
// Direct-mapped instruction cache controller. Holds the valid, tag and
// line arrays, looks up one request at a time and asks the refill
// engine for the line on a miss. A flush clears every valid bit once
// the controller is back in IDLE.

module icache_ctrl import fetch_pkg::*; #(
    parameter int NUM_SETS = 64
) (
    input  logic   CLK,
    input  logic   RST,
    input  logic   flush_i,
    icache_if.cache ic,
    ifill_if.ctrl   fill
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = $bits(block_addr_t) - IDX_W;

    icache_state_e state_q;
    icache_state_e state_d;

    logic [NUM_SETS-1:0] valid_q;
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    line_t               data_mem [NUM_SETS];

    block_addr_t      req_block_q;
    beat_idx_t        req_quarter_q;
    logic             flush_pend_q;
    logic             resp_valid_q;
    beat_t            resp_block_q;
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             hit;
    logic             accept;

    assign idx = req_block_q[IDX_W-1:0];
    assign tag = req_block_q[$bits(block_addr_t)-1:IDX_W];
    assign hit = valid_q[idx] && (tag_mem[idx] == tag);

    // Pending flush blocks new requests
    assign ic.req_ready = (state_q == IDLE) && !flush_pend_q;
    assign accept       = ic.req_valid && ic.req_ready;

    // Miss request leaves in the lookup cycle
    assign fill.fill_req   = (state_q == LOOKUP) && !hit;
    assign fill.fill_block = req_block_q;

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (flush_pend_q) begin
                    state_d = FLUSH;
                end else if (accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP:  state_d = hit ? IDLE : MISS;
            // Wait for the refill engine to take the miss
            MISS:    state_d = fill.fill_busy ? FILL : MISS;
            FILL:    state_d = fill.fill_done ? IDLE : FILL;
            FLUSH:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q      <= IDLE;
            valid_q      <= '0;
            flush_pend_q <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_q <= ((state_q == LOOKUP) && hit) ||
                            ((state_q == FILL) && fill.fill_done);
            if (flush_i) begin
                flush_pend_q <= 1'b1;
            end else if (state_q == FLUSH) begin
                flush_pend_q <= 1'b0;
            end
            if (state_q == FLUSH) begin
                valid_q <= '0;
            end else if ((state_q == FILL) && fill.fill_done) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    // Arrays and request payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_block_q   <= block_of(ic.req_paddr);
            req_quarter_q <= quarter_of(ic.req_paddr);
        end
        if ((state_q == FILL) && fill.fill_done) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= fill.fill_line;
            resp_block_q  <= line_quarter(fill.fill_line, req_quarter_q);
        end else if (state_q == LOOKUP) begin
            resp_block_q  <= line_quarter(data_mem[idx], req_quarter_q);
        end
    end

    assign ic.resp_valid = resp_valid_q;
    assign ic.resp_block = resp_block_q;

    // Responses coincide with the return to IDLE from LOOKUP or FILL
    a_resp_src: assert property (@(posedge CLK) disable iff (!RST)
        resp_valid_q == ((state_q == IDLE) && ($past(state_q) inside {LOOKUP, FILL})));

endmodule

// File: icache/icache_refill.sv
// Refill engine. Sends one L2 acquire per miss, gathers the four grant
// beats into a line and hands it back with fill_done. The grant port
// is always ready.

module icache_refill import fetch_pkg::*; (
    input  logic        CLK,
    input  logic        RST,
    ifill_if.refill     fill,

    output logic        mem_acquire_valid_o,
    output block_addr_t mem_acquire_block_o,
    input  logic        mem_grant_valid_i,
    input  beat_idx_t   mem_grant_beat_i,
    input  beat_t       mem_grant_data_i,

    output logic        pmu_imiss_time_o
);

    logic                             acq_valid_q;
    block_addr_t                      acq_block_q;
    logic                             busy_q;
    logic                             done_q;
    beat_idx_t                        exp_beat_q;
    beat_t [BEATS_PER_LINE-1:0]       beats_q;
    logic                             last_grant;

    // Beat 3 is the acknowledge
    assign last_grant = mem_grant_valid_i && (mem_grant_beat_i == LAST_BEAT);

    // ------------------------------------------------------------------
    // Miss tracking
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            acq_valid_q <= 1'b0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            exp_beat_q  <= '0;
        end else begin
            acq_valid_q <= fill.fill_req && !busy_q;
            done_q      <= last_grant;
            if (fill.fill_req && !busy_q) begin
                busy_q     <= 1'b1;
                exp_beat_q <= '0;
            end else begin
                if (done_q) begin
                    busy_q <= 1'b0;
                end
                if (mem_grant_valid_i) begin
                    exp_beat_q <= exp_beat_q + 2'd1;
                end
            end
        end
    end

    // Block address and line assembly
    always_ff @(posedge CLK) begin
        if (fill.fill_req && !busy_q) begin
            acq_block_q <= fill.fill_block;
        end
        if (mem_grant_valid_i) begin
            beats_q[mem_grant_beat_i] <= mem_grant_data_i;
        end
    end

    assign mem_acquire_valid_o = acq_valid_q;
    assign mem_acquire_block_o = acq_block_q;
    assign fill.fill_done      = done_q;
    assign fill.fill_line      = beats_q;
    assign fill.fill_busy      = busy_q;
    assign pmu_imiss_time_o    = busy_q;

    a_no_idle_grant: assert property (@(posedge CLK) disable iff (!RST)
        mem_grant_valid_i |-> busy_q);

    a_beat_order: assert property (@(posedge CLK) disable iff (!RST)
        mem_grant_valid_i |-> mem_grant_beat_i == exp_beat_q);

endmodule

// File: verilog/fetch_top.sv
// Top level of the instruction-fetch subsystem. Connects the fetch
// port, the cache controller and the refill engine, and derives the
// PMU events. All external signals are plain ports.

module fetch_top import fetch_pkg::*; #(
    parameter int NUM_SETS = 64
) (
    input  logic        CLK,
    input  logic        RST,

    // Fetch stage
    input  logic        fetch_req_valid_i,
    input  addr_t       fetch_req_addr_i,
    output logic        fetch_req_ready_o,
    output logic        fetch_resp_valid_o,
    output insn_t       fetch_resp_insn_o,
    input  logic        fetch_resp_ready_i,

    // L2 acquire and grant
    output logic        mem_acquire_valid_o,
    output block_addr_t mem_acquire_block_o,
    input  logic        mem_grant_valid_i,
    input  beat_idx_t   mem_grant_beat_i,
    input  beat_t       mem_grant_data_i,

    // Boot ROM
    input  logic        brom_ready_i,
    output logic        brom_req_valid_o,
    output brom_addr_t  brom_req_addr_o,
    input  logic        brom_resp_valid_i,
    input  insn_t       brom_resp_data_i,

    // Configuration
    input  logic        boot_mode_i,
    input  logic        flush_i,

    // PMU
    input  logic        l2_hit_i,
    output logic        pmu_icache_req_o,
    output logic        pmu_icache_busy_o,
    output logic        pmu_imiss_time_o,
    output logic        pmu_buffer_miss_o
);

    icache_if ic ();
    ifill_if  fill ();

    fetch_port u_fetch_port (
        .CLK                (CLK),
        .RST                (RST),
        .fetch_req_valid_i  (fetch_req_valid_i),
        .fetch_req_addr_i   (fetch_req_addr_i),
        .fetch_req_ready_o  (fetch_req_ready_o),
        .fetch_resp_valid_o (fetch_resp_valid_o),
        .fetch_resp_insn_o  (fetch_resp_insn_o),
        .fetch_resp_ready_i (fetch_resp_ready_i),
        .boot_mode_i        (boot_mode_i),
        .brom_ready_i       (brom_ready_i),
        .brom_resp_valid_i  (brom_resp_valid_i),
        .brom_resp_data_i   (brom_resp_data_i),
        .brom_req_valid_o   (brom_req_valid_o),
        .brom_req_addr_o    (brom_req_addr_o),
        .ic                 (ic.port)
    );

    icache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) u_icache_ctrl (
        .CLK     (CLK),
        .RST     (RST),
        .flush_i (flush_i),
        .ic      (ic.cache),
        .fill    (fill.ctrl)
    );

    icache_refill u_icache_refill (
        .CLK                 (CLK),
        .RST                 (RST),
        .fill                (fill.refill),
        .mem_acquire_valid_o (mem_acquire_valid_o),
        .mem_acquire_block_o (mem_acquire_block_o),
        .mem_grant_valid_i   (mem_grant_valid_i),
        .mem_grant_beat_i    (mem_grant_beat_i),
        .mem_grant_data_i    (mem_grant_data_i),
        .pmu_imiss_time_o    (pmu_imiss_time_o)
    );

    // ------------------------------------------------------------------
    // PMU events
    // ------------------------------------------------------------------
    assign pmu_icache_req_o  = ic.req_valid && ic.req_ready;
    assign pmu_icache_busy_o = !ic.req_ready;
    // L2 hit qualified by the acknowledge beat
    assign pmu_buffer_miss_o = mem_grant_valid_i && (mem_grant_beat_i == LAST_BEAT) &&
                               l2_hit_i;

endmodule

// File: verification/tb_mem_models.sv
// Responder models for the fetch subsystem testbench.
// l2_responder answers each acquire with four grant beats after random gaps.
// brom_responder handshakes boot-ROM requests and returns data after a delay.
// Both drive their outputs on the falling clock edge.

module l2_responder import fetch_pkg::*; #(
    parameter logic [31:0] SEED = 32'h0,
    parameter logic [31:0] KEY  = 32'h0
) (
    input  logic        CLK,
    input  logic        acq_valid,
    input  block_addr_t acq_block,
    output logic        grant_valid,
    output beat_idx_t   grant_beat,
    output beat_t       grant_data,
    output logic        l2_hit
);

    integer      seed = SEED;
    logic [31:0] rnd;
    block_addr_t blk;

    // Each word holds its word address mixed with the key
    function automatic beat_t beat_data(block_addr_t b, beat_idx_t q);
        beat_t      d;
        logic [1:0] k;
        for (int i = 0; i < 4; i++) begin
            k = i[1:0];
            d[i * 32 +: 32] = {2'b00, b, q, k} ^ KEY;
        end
        return d;
    endfunction

    initial begin
        grant_valid = 1'b0;
        grant_beat  = '0;
        grant_data  = '0;
        l2_hit      = 1'b0;
        forever begin
            @(negedge CLK);
            if (acq_valid) begin
                blk = acq_block;
                rnd = $random(seed);
                repeat (rnd[2:0]) @(negedge CLK);
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    rnd         = $random(seed);
                    grant_valid = 1'b1;
                    grant_beat  = b[1:0];
                    grant_data  = beat_data(blk, b[1:0]);
                    l2_hit      = rnd[0];
                    @(negedge CLK);
                    grant_valid = 1'b0;
                    l2_hit      = 1'b0;
                    repeat (rnd[2:1]) @(negedge CLK);
                end
            end
        end
    end

endmodule

module brom_responder import fetch_pkg::*; #(
    parameter logic [31:0] SEED = 32'h0,
    parameter logic [31:0] KEY  = 32'h0
) (
    input  logic       CLK,
    input  logic       req_valid,
    input  brom_addr_t req_addr,
    output logic       ready,
    output logic       resp_valid,
    output insn_t      resp_data
);

    integer      seed = SEED;
    logic [31:0] rnd;
    brom_addr_t  addr;

    initial begin
        ready      = 1'b0;
        resp_valid = 1'b0;
        resp_data  = '0;
        forever begin
            @(negedge CLK);
            rnd   = $random(seed);
            ready = rnd[0];
            // Transfer happens on the next rising edge
            if (req_valid && ready) begin
                addr = req_addr;
                @(negedge CLK);
                ready = 1'b0;
                repeat (rnd[3:1]) @(negedge CLK);
                resp_valid = 1'b1;
                resp_data  = {8'h00, addr} ^ KEY;
                @(negedge CLK);
                resp_valid = 1'b0;
            end
        end
    end

endmodule

// File: verification/tb_fetch_top.sv
// Testbench for the instruction-fetch subsystem.
// Random fetches through cache and boot ROM, checked against a
// direct-mapped tag model, with flushes, back-pressure and PMU checks.

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int          NUM_SETS    = 64;
    localparam int          TOTAL       = 400;
    localparam int          CYCLE_BOUND = 120;
    localparam logic [31:0] L2_KEY      = 32'h5a3c_96e1;
    localparam logic [31:0] BROM_KEY    = 32'hc0de_b007;

    logic CLK, RST, fetch_req_valid_i, fetch_req_ready_o, fetch_resp_valid_o;
    logic fetch_resp_ready_i, mem_acquire_valid_o, mem_grant_valid_i, brom_ready_i;
    logic brom_req_valid_o, brom_resp_valid_i, boot_mode_i, flush_i, l2_hit_i;
    logic pmu_icache_req_o, pmu_icache_busy_o, pmu_imiss_time_o, pmu_buffer_miss_o;
    addr_t       fetch_req_addr_i;
    insn_t       fetch_resp_insn_o, brom_resp_data_i;
    block_addr_t mem_acquire_block_o, last_acq;
    beat_idx_t   mem_grant_beat_i;
    beat_t       mem_grant_data_i;
    brom_addr_t  brom_req_addr_o;

    integer      seed = 32'h9434c151;
    logic [31:0] rnd;
    int          errors, checks, acq_count, icreq_count, cached_fetches, err_mark;
    logic        model_valid [NUM_SETS];
    block_addr_t model_block [NUM_SETS];
    addr_t       seen [$];

    fetch_top #(.NUM_SETS(NUM_SETS)) DUT (.*);

    l2_responder #(.SEED(32'h9434c151), .KEY(L2_KEY)) u_l2 (
        .CLK(CLK), .acq_valid(mem_acquire_valid_o), .acq_block(mem_acquire_block_o),
        .grant_valid(mem_grant_valid_i), .grant_beat(mem_grant_beat_i),
        .grant_data(mem_grant_data_i), .l2_hit(l2_hit_i));

    brom_responder #(.SEED(32'h9434c151), .KEY(BROM_KEY)) u_brom (
        .CLK(CLK), .req_valid(brom_req_valid_o), .req_addr(brom_req_addr_o),
        .ready(brom_ready_i), .resp_valid(brom_resp_valid_i), .resp_data(brom_resp_data_i));

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        #((TOTAL * CYCLE_BOUND + 20) * 4);
        $display("Timeout: the run did not finish within the cycle bound");
        $display("Test FAILED");
        $finish;
    end

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Mismatch at %0t: %s", $time, msg);
        end
    endtask

    // ------------------------------------------------------------------
    // Bus monitor sampled on the rising edge
    // ------------------------------------------------------------------
    always @(posedge CLK) begin
        if (RST) begin
            if (mem_acquire_valid_o) begin
                acq_count++;
                last_acq = mem_acquire_block_o;
                check(pmu_imiss_time_o, "miss-time event low during acquire");
                check(pmu_icache_busy_o, "busy event low during acquire");
            end
            if (!boot_mode_i && fetch_req_ready_o) begin
                check(!pmu_icache_busy_o, "busy event high while the cache takes requests");
            end
            if (pmu_icache_req_o) icreq_count++;
            check(pmu_buffer_miss_o == (mem_grant_valid_i && l2_hit_i &&
                  mem_grant_beat_i == LAST_BEAT), "buffer-miss event wrong");
            if (fetch_resp_valid_o) check(!fetch_req_ready_o, "ready while response held");
        end
    end

    // Small window, 128 lines over 64 sets, so conflicts occur
    function automatic addr_t rand_addr();
        paddr_t p;
        rnd = $random(seed);
        p = 32'h8000_0000 | {19'h0, rnd[12:2], 2'b00};
        return {rnd[31:24], p};
    endfunction

    task automatic fetch_and_check(input addr_t addr, input bit boot);
        int          cycles;
        int          idx;
        int          acq_before;
        bit          miss;
        block_addr_t blk;
        insn_t       exp;
        insn_t       held;
        blk  = addr[31:6];
        idx  = int'(blk % NUM_SETS);
        miss = !boot && !(model_valid[idx] && model_block[idx] == blk);
        exp  = boot ? ({8'h00, addr[25:2]} ^ BROM_KEY) : ({2'b00, addr[31:2]} ^ L2_KEY);
        @(negedge CLK);
        boot_mode_i       = boot;
        fetch_req_valid_i = 1'b0;
        @(negedge CLK);
        fetch_req_valid_i = 1'b1;
        fetch_req_addr_i  = addr;
        acq_before        = acq_count;
        while (!fetch_req_ready_o) @(negedge CLK);
        @(negedge CLK);
        fetch_req_valid_i = 1'b0;
        cycles = 1;
        while (!fetch_resp_valid_o) begin
            @(negedge CLK);
            cycles++;
        end
        check(fetch_resp_insn_o == exp, $sformatf("fetch %h got %h expected %h",
              addr, fetch_resp_insn_o, exp));
        check(acq_count - acq_before == (miss ? 1 : 0),
              $sformatf("fetch %h acquire count %0d", addr, acq_count - acq_before));
        if (miss) check(last_acq == blk, $sformatf("acquire block %h expected %h", last_acq, blk));
        if (!boot && !miss) check(cycles == 3, $sformatf("hit latency %0d", cycles));
        if (!boot) begin
            model_valid[idx] = 1'b1;
            model_block[idx] = blk;
            cached_fetches++;
            seen.push_back(addr);
        end
        // Hold the response while offering a request that must not be taken
        held = fetch_resp_insn_o;
        rnd  = $random(seed);
        while (rnd[1:0] != 2'd0) begin
            fetch_req_valid_i = 1'b1;
            fetch_req_addr_i  = addr ^ 40'h40;
            @(negedge CLK);
            check(fetch_resp_valid_o && fetch_resp_insn_o == held && !fetch_req_ready_o,
                  "held response changed or request accepted");
            rnd = $random(seed);
        end
        fetch_req_valid_i  = 1'b0;
        fetch_resp_ready_i = 1'b1;
        @(negedge CLK);
        fetch_resp_ready_i = 1'b0;
        check(!fetch_resp_valid_o, "response not released");
    endtask

    task automatic pulse_flush();
        @(negedge CLK);
        flush_i = 1'b1;
        @(negedge CLK);
        flush_i = 1'b0;
        for (int i = 0; i < NUM_SETS; i++) model_valid[i] = 1'b0;
    endtask

    task automatic end_test(input string name);
        $display("%-10s finished, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        addr_t a;
        int    n;
        bit    boot;
        RST = 1'b0;
        fetch_req_valid_i = 1'b0;
        fetch_req_addr_i = '0;
        fetch_resp_ready_i = 1'b0;
        boot_mode_i = 1'b0;
        flush_i = 1'b0;
        for (int i = 0; i < NUM_SETS; i++) model_valid[i] = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b1;
        check(fetch_req_ready_o && !fetch_resp_valid_o && !mem_acquire_valid_o &&
              !brom_req_valid_o && !pmu_icache_req_o && !pmu_imiss_time_o &&
              !pmu_buffer_miss_o, "outputs wrong after reset");
        for (int i = 0; i < 120; i++) fetch_and_check(rand_addr(), 1'b0);
        end_test("random");
        for (int i = 0; i < 40; i++) begin
            a = rand_addr();
            fetch_and_check(a, 1'b0);
            rnd = $random(seed);
            fetch_and_check({a[39:6], rnd[3:0], 2'b00}, 1'b0);
        end
        end_test("repeat");
        for (int i = 0; i < 40; i++) fetch_and_check(rand_addr(), 1'b1);
        end_test("boot");
        for (int r = 0; r < 6; r++) begin
            for (int i = 0; i < 4; i++) fetch_and_check(rand_addr(), 1'b0);
            pulse_flush();
            n = seen.size();
            for (int i = 0; i < 4; i++) fetch_and_check(seen[n - 1 - i], 1'b0);
        end
        end_test("flush");
        for (int i = 0; i < 80; i++) begin
            rnd  = $random(seed);
            boot = (rnd[7:5] == 3'd0);
            if (rnd[4:0] == 5'd0) pulse_flush();
            a = rand_addr();
            fetch_and_check(a, boot);
        end
        end_test("mixed");
        check(icreq_count == cached_fetches, $sformatf("icache request events %0d expected %0d",
              icreq_count, cached_fetches));
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
common/fetch_pkg.sv
common/icache_if.sv
common/ifill_if.sv
verilog/fetch_port.sv
icache/icache_ctrl.sv
icache/icache_refill.sv
verilog/fetch_top.sv
verification/tb_mem_models.sv
verification/tb_fetch_top.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the fetch subsystem simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_fetch_top \
    -o sim_fetch > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_fetch > sim.log 2>&1
cat sim.log

grep -qx "Test OK" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
